// ==== logic/crtc_pkg.sv ====
package crtc_pkg;

	// Register select latched by an address write
	typedef logic [4:0] reg_idx_t;

	// Framestore address and character row address
	typedef logic [13:0] ma_t;
	typedef logic [4:0]  ra_t;

	// 6845 register map
	localparam reg_idx_t REG_H_TOTAL      = 5'd0;
	localparam reg_idx_t REG_H_DISP       = 5'd1;
	localparam reg_idx_t REG_H_SYNC_POS   = 5'd2;
	localparam reg_idx_t REG_SYNC_WIDTH   = 5'd3;
	localparam reg_idx_t REG_V_TOTAL      = 5'd4;
	localparam reg_idx_t REG_V_TOTAL_ADJ  = 5'd5;
	localparam reg_idx_t REG_V_DISP       = 5'd6;
	localparam reg_idx_t REG_V_SYNC_POS   = 5'd7;
	localparam reg_idx_t REG_MODE         = 5'd8;
	localparam reg_idx_t REG_MAX_SCANLINE = 5'd9;
	localparam reg_idx_t REG_CURSOR_START = 5'd10;
	localparam reg_idx_t REG_CURSOR_END   = 5'd11;
	localparam reg_idx_t REG_START_HI     = 5'd12;
	localparam reg_idx_t REG_START_LO     = 5'd13;
	localparam reg_idx_t REG_CURSOR_HI    = 5'd14;
	localparam reg_idx_t REG_CURSOR_LO    = 5'd15;
	// Light pen pair, the highest select a 6845 decodes
	localparam reg_idx_t REG_LPEN_LO      = 5'd17;

	typedef enum logic [1:0] {H_DISP, H_FRONT, H_PULSE, H_BACK} h_state_t;
	typedef enum logic [1:0] {V_DISP, V_FRONT, V_PULSE, V_BACK} v_state_t;

endpackage

// ==== logic/crtc_regs.sv ====
module crtc_regs (
	input  logic            CLK,
	input  logic            nRESET,
	input  logic            cs_n,
	input  logic            rw,
	input  logic            a0,
	input  logic [7:0]      wr_data,
	input  logic            proc_en,
	output logic [7:0]      rd_data,
	output logic [7:0]      horz_total,
	output logic [7:0]      horz_display,
	output logic [7:0]      horz_syncpos,
	output logic [7:0]      hv_sync,
	output logic [6:0]      vert_total,
	output logic [4:0]      vert_total_adj,
	output logic [6:0]      vert_display,
	output logic [6:0]      vert_syncpos,
	output logic [7:0]      display_mode,
	output logic [4:0]      max_scanline,
	output logic [1:0]      cursor_blink_mode,
	output logic [4:0]      cursor_start_row,
	output logic [4:0]      cursor_end_row,
	output crtc_pkg::ma_t   start_addr,
	output crtc_pkg::ma_t   cursor_addr,
	output logic            h_restart,
	output logic            v_restart
);
	import crtc_pkg::*;

	reg_idx_t reg_sel;
	logic     bus_wr;
	logic     data_wr;

	assign bus_wr  = !cs_n && !rw && proc_en;
	assign data_wr = bus_wr && a0;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			reg_sel           <= '0;
			horz_total        <= '0;
			horz_display      <= '0;
			horz_syncpos      <= '0;
			hv_sync           <= '0;
			vert_total        <= '0;
			vert_total_adj    <= '0;
			vert_display      <= '0;
			vert_syncpos      <= '0;
			display_mode      <= '0;
			max_scanline      <= '0;
			cursor_blink_mode <= '0;
			cursor_start_row  <= '0;
			cursor_end_row    <= '0;
			start_addr        <= '0;
			cursor_addr       <= '0;
			h_restart         <= 1'b0;
			v_restart         <= 1'b0;
		end else begin
			// Restart the timing chains once the new values are visible
			h_restart <= data_wr && (reg_sel <= REG_SYNC_WIDTH);
			v_restart <= data_wr && (reg_sel >= REG_V_TOTAL) && (reg_sel <= REG_V_SYNC_POS);
			if (bus_wr && !a0) begin
				reg_sel <= wr_data[4:0];
			end else if (data_wr) begin
				case (reg_sel)
				REG_H_TOTAL:      horz_total     <= wr_data;
				REG_H_DISP:       horz_display   <= wr_data;
				REG_H_SYNC_POS:   horz_syncpos   <= wr_data;
				REG_SYNC_WIDTH:   hv_sync        <= wr_data;
				REG_V_TOTAL:      vert_total     <= wr_data[6:0];
				REG_V_TOTAL_ADJ:  vert_total_adj <= wr_data[4:0];
				REG_V_DISP:       vert_display   <= wr_data[6:0];
				REG_V_SYNC_POS:   vert_syncpos   <= wr_data[6:0];
				REG_MODE:         display_mode   <= wr_data;
				REG_MAX_SCANLINE: max_scanline   <= wr_data[4:0];
				REG_CURSOR_START: begin
					cursor_blink_mode <= wr_data[6:5];
					cursor_start_row  <= wr_data[4:0];
				end
				REG_CURSOR_END:   cursor_end_row     <= wr_data[4:0];
				REG_START_HI:     start_addr[13:8]   <= wr_data[5:0];
				REG_START_LO:     start_addr[7:0]    <= wr_data;
				REG_CURSOR_HI:    cursor_addr[13:8]  <= wr_data[5:0];
				REG_CURSOR_LO:    cursor_addr[7:0]   <= wr_data;
				default: ;
				endcase
			end
		end
	end

	// Only the cursor address reads back
	always_comb begin
		rd_data = 8'h00;
		if (!cs_n && rw && a0) begin
			case (reg_sel)
			REG_CURSOR_HI: rd_data = {2'b00, cursor_addr[13:8]};
			REG_CURSOR_LO: rd_data = cursor_addr[7:0];
			default:       rd_data = 8'h00;
			endcase
		end
	end

	// Software must select a decoded register before loading it
	a_sel_in_range: assert property (@(posedge CLK) disable iff (!nRESET)
		data_wr |-> (reg_sel <= REG_LPEN_LO));

endmodule

// ==== logic/crtc_horiz.sv ====
module crtc_horiz (
	input  logic       CLK,
	input  logic       nRESET,
	input  logic       char_en,
	input  logic [7:0] horz_total,
	input  logic [7:0] horz_display,
	input  logic [7:0] horz_syncpos,
	input  logic [3:0] hsync_width,
	input  logic       h_restart,
	output logic       new_line,
	output logic       h_disp,
	output logic       hsync
);
	import crtc_pkg::*;

	h_state_t   h_state;
	logic [7:0] h_count;
	logic [7:0] h_next;
	logic [3:0] pulse_cnt;

	assign new_line = (h_count == horz_total) || h_restart;
	assign h_next   = new_line ? 8'd0 : h_count + 8'd1;
	assign h_disp   = (h_state == H_DISP);
	assign hsync    = (h_state == H_PULSE);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			h_count   <= '0;
			pulse_cnt <= '0;
			h_state   <= H_BACK;
		end else if (char_en) begin
			h_count <= h_next;
			if (new_line) begin
				// Zero displayed characters skips straight to the front porch
				h_state   <= (horz_display == 8'd0) ? H_FRONT : H_DISP;
				pulse_cnt <= '0;
			end else begin
				case (h_state)
				H_DISP, H_FRONT: begin
					// Sync may start right where display ends
					if (h_next == horz_syncpos &&
						(h_state == H_FRONT || h_next == horz_display)) begin
						h_state   <= (hsync_width != 4'd0) ? H_PULSE : H_BACK;
						pulse_cnt <= 4'd1;
					end else if (h_state == H_DISP && h_next == horz_display) begin
						h_state <= H_FRONT;
					end
				end
				H_PULSE: begin
					if (pulse_cnt == hsync_width)
						h_state <= H_BACK;
					else
						pulse_cnt <= pulse_cnt + 4'd1;
				end
				default: ;
				endcase
			end
		end
	end

	// Sync pulse lies in the undisplayed part of the line
	a_hsync_blank: assert property (@(posedge CLK) disable iff (!nRESET)
		hsync |-> ((h_count >= horz_display) || h_restart));

endmodule

// ==== logic/crtc_vert.sv ====
module crtc_vert (
	input  logic       CLK,
	input  logic       nRESET,
	input  logic       char_en,
	input  logic       new_line,
	input  logic       row_end,
	input  logic [6:0] vert_total,
	input  logic [4:0] vert_total_adj,
	input  logic [6:0] vert_display,
	input  logic [6:0] vert_syncpos,
	input  logic [3:0] vsync_width,
	input  logic       v_restart,
	output logic       new_char_row,
	output logic       new_frame,
	output logic       v_disp,
	output logic       vsync,
	output logic       field
);
	import crtc_pkg::*;

	v_state_t   v_state;
	logic [6:0] row_cnt;
	logic [6:0] row_next;
	logic [4:0] adj_cnt;
	logic       in_adj;
	logic [3:0] pulse_cnt;
	logic       last_row;
	logic       adj_done;
	logic       rows_done;

	assign new_char_row = new_line && row_end;
	assign row_next     = row_cnt + 7'd1;
	assign last_row     = (row_cnt == vert_total);
	assign adj_done     = in_adj && (adj_cnt == vert_total_adj);
	// Without adjust lines the frame ends with the last character row
	assign rows_done    = !in_adj && new_char_row && last_row && (vert_total_adj == 5'd0);
	assign new_frame    = (new_line && adj_done) || rows_done || v_restart;
	assign v_disp       = (v_state == V_DISP);
	assign vsync        = (v_state == V_PULSE);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			row_cnt   <= '0;
			adj_cnt   <= '0;
			in_adj    <= 1'b0;
			pulse_cnt <= '0;
			field     <= 1'b0;
			v_state   <= V_BACK;
		end else if (char_en) begin
			if (new_frame) begin
				row_cnt   <= '0;
				adj_cnt   <= '0;
				in_adj    <= 1'b0;
				pulse_cnt <= '0;
				// A pulse that runs into the frame start ends here
				if (v_state == V_PULSE)
					field <= ~field;
				v_state   <= (vert_display == 7'd0) ? V_FRONT : V_DISP;
			end else if (new_line) begin
				if (in_adj) begin
					adj_cnt <= adj_cnt + 5'd1;
				end else if (new_char_row) begin
					// Last row with adjust pending, count single lines from here
					if (last_row) begin
						in_adj  <= 1'b1;
						adj_cnt <= 5'd1;
					end else begin
						row_cnt <= row_next;
					end
				end
				case (v_state)
				V_DISP, V_FRONT: begin
					if (new_char_row && !in_adj) begin
						if (row_next == vert_syncpos &&
							(v_state == V_FRONT || row_next == vert_display)) begin
							v_state   <= (vsync_width != 4'd0) ? V_PULSE : V_BACK;
							pulse_cnt <= 4'd1;
						end else if (v_state == V_DISP && row_next == vert_display) begin
							v_state <= V_FRONT;
						end
					end
				end
				V_PULSE: begin
					if (pulse_cnt == vsync_width) begin
						v_state <= V_BACK;
						field   <= ~field;
					end else begin
						pulse_cnt <= pulse_cnt + 4'd1;
					end
				end
				default: ;
				endcase
			end
		end
	end

	// Row and adjust counters stay inside the programmed frame
	a_frame_bounds: assert property (@(posedge CLK) disable iff (!nRESET)
		!v_restart |-> ((row_cnt <= vert_total) &&
			(!in_adj || adj_cnt <= vert_total_adj)));

endmodule

// ==== logic/crtc_addr.sv ====
module crtc_addr (
	input  logic          CLK,
	input  logic          nRESET,
	input  logic          char_en,
	input  logic          new_line,
	input  logic          new_char_row,
	input  logic          new_frame,
	input  logic          field,
	input  logic [7:0]    display_mode,
	input  logic [4:0]    max_scanline,
	input  logic [7:0]    horz_display,
	input  crtc_pkg::ma_t start_addr,
	output crtc_pkg::ma_t mem_addr,
	output crtc_pkg::ra_t row_addr,
	output logic          row_end
);
	import crtc_pkg::*;

	ma_t  row_base;
	ma_t  next_base;
	logic interlace_video;
	logic odd_start;
	ra_t  row_step;

	// Interlace sync and video, both mode bits set
	assign interlace_video = &display_mode[1:0];
	assign odd_start       = interlace_video && field;
	assign row_step        = interlace_video ? 5'd2 : 5'd1;
	assign next_base       = row_base + {6'b000000, horz_display};

	// In interlace video the row count goes by twos, so bit 0 is don't care
	assign row_end = (row_addr[4:1] == max_scanline[4:1]) &&
		(interlace_video || row_addr[0] == max_scanline[0]);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			row_base <= '0;
			mem_addr <= '0;
			row_addr <= '0;
		end else if (char_en) begin
			if (new_frame) begin
				row_base <= start_addr;
				mem_addr <= start_addr;
				row_addr <= {4'b0000, odd_start};
			end else if (new_char_row) begin
				row_base <= next_base;
				mem_addr <= next_base;
				row_addr <= {4'b0000, odd_start};
			end else if (new_line) begin
				mem_addr <= row_base;
				row_addr <= row_addr + row_step;
			end else begin
				mem_addr <= mem_addr + 14'd1;
			end
		end
	end

endmodule

// ==== logic/crtc_video_out.sv ====
module crtc_video_out (
	input  logic          CLK,
	input  logic          nRESET,
	input  logic          char_en,
	input  logic          h_disp,
	input  logic          v_disp,
	input  logic          new_frame,
	input  crtc_pkg::ma_t mem_addr,
	input  crtc_pkg::ra_t row_addr,
	input  crtc_pkg::ma_t cursor_addr,
	input  logic [4:0]    cursor_start_row,
	input  logic [4:0]    cursor_end_row,
	input  logic [1:0]    cursor_blink_mode,
	input  logic [7:0]    display_mode,
	output logic          disen,
	output logic          cursor
);
	logic [5:0] blink_cnt;
	logic       cursor_on;
	logic       disp_now;
	logic       at_cursor;
	logic [1:0] disen_dly;
	logic [1:0] cursor_dly;

	// Skew select, values 2 and 3 both give two ticks
	function automatic logic skew_pick(input logic [1:0] sel, input logic now,
		input logic [1:0] dly);
		case (sel)
		2'd0:    skew_pick = now;
		2'd1:    skew_pick = dly[0];
		default: skew_pick = dly[1];
		endcase
	endfunction

	assign disp_now  = h_disp && v_disp;
	assign at_cursor = cursor_on && (mem_addr == cursor_addr) &&
		(row_addr >= cursor_start_row) && (row_addr <= cursor_end_row);

	assign disen  = skew_pick(display_mode[5:4], disp_now, disen_dly);
	assign cursor = skew_pick(display_mode[7:6], at_cursor, cursor_dly);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			blink_cnt  <= '0;
			cursor_on  <= 1'b0;
			disen_dly  <= '0;
			cursor_dly <= '0;
		end else if (char_en) begin
			disen_dly  <= {disen_dly[0], disp_now};
			cursor_dly <= {cursor_dly[0], at_cursor};
			// Blink phase is picked once per frame
			if (new_frame) begin
				blink_cnt <= blink_cnt + 6'd1;
				case (cursor_blink_mode)
				2'd0: cursor_on <= 1'b1;
				2'd1: cursor_on <= 1'b0;
				2'd2: cursor_on <= blink_cnt[4];
				2'd3: cursor_on <= blink_cnt[5];
				endcase
			end
		end
	end

endmodule

// ==== logic/crtc_top.sv ====
module crtc_top (
	input  logic          CLK,
	input  logic          nRESET,
	input  logic          char_en,
	input  logic          proc_en,
	input  logic          cs_n,
	input  logic          rw,
	input  logic          a0,
	input  logic [7:0]    wr_data,
	output logic [7:0]    rd_data,
	output logic          hsync,
	output logic          vsync,
	output logic          disen,
	output logic          cursor,
	output crtc_pkg::ma_t mem_addr,
	output crtc_pkg::ra_t row_addr
);
	import crtc_pkg::*;

	logic [7:0] horz_total;
	logic [7:0] horz_display;
	logic [7:0] horz_syncpos;
	logic [7:0] hv_sync;
	logic [6:0] vert_total;
	logic [4:0] vert_total_adj;
	logic [6:0] vert_display;
	logic [6:0] vert_syncpos;
	logic [7:0] display_mode;
	logic [4:0] max_scanline;
	logic [1:0] cursor_blink_mode;
	logic [4:0] cursor_start_row;
	logic [4:0] cursor_end_row;
	ma_t        start_addr;
	ma_t        cursor_addr;
	logic       h_restart;
	logic       v_restart;
	logic       new_line;
	logic       h_disp;
	logic       row_end;
	logic       new_char_row;
	logic       new_frame;
	logic       v_disp;
	logic       field;

	crtc_regs u_regs (
		.CLK(CLK), .nRESET(nRESET), .cs_n(cs_n), .rw(rw), .a0(a0),
		.wr_data(wr_data), .proc_en(proc_en), .rd_data(rd_data),
		.horz_total(horz_total), .horz_display(horz_display),
		.horz_syncpos(horz_syncpos), .hv_sync(hv_sync),
		.vert_total(vert_total), .vert_total_adj(vert_total_adj),
		.vert_display(vert_display), .vert_syncpos(vert_syncpos),
		.display_mode(display_mode), .max_scanline(max_scanline),
		.cursor_blink_mode(cursor_blink_mode), .cursor_start_row(cursor_start_row),
		.cursor_end_row(cursor_end_row), .start_addr(start_addr),
		.cursor_addr(cursor_addr), .h_restart(h_restart), .v_restart(v_restart)
	);

	// Sync widths share R3, low nibble horizontal and high nibble vertical
	crtc_horiz u_horiz (
		.CLK(CLK), .nRESET(nRESET), .char_en(char_en),
		.horz_total(horz_total), .horz_display(horz_display),
		.horz_syncpos(horz_syncpos), .hsync_width(hv_sync[3:0]),
		.h_restart(h_restart), .new_line(new_line), .h_disp(h_disp), .hsync(hsync)
	);

	crtc_vert u_vert (
		.CLK(CLK), .nRESET(nRESET), .char_en(char_en), .new_line(new_line),
		.row_end(row_end), .vert_total(vert_total), .vert_total_adj(vert_total_adj),
		.vert_display(vert_display), .vert_syncpos(vert_syncpos),
		.vsync_width(hv_sync[7:4]), .v_restart(v_restart),
		.new_char_row(new_char_row), .new_frame(new_frame), .v_disp(v_disp),
		.vsync(vsync), .field(field)
	);

	crtc_addr u_addr (
		.CLK(CLK), .nRESET(nRESET), .char_en(char_en), .new_line(new_line),
		.new_char_row(new_char_row), .new_frame(new_frame), .field(field),
		.display_mode(display_mode), .max_scanline(max_scanline),
		.horz_display(horz_display), .start_addr(start_addr),
		.mem_addr(mem_addr), .row_addr(row_addr), .row_end(row_end)
	);

	crtc_video_out u_video_out (
		.CLK(CLK), .nRESET(nRESET), .char_en(char_en), .h_disp(h_disp),
		.v_disp(v_disp), .new_frame(new_frame), .mem_addr(mem_addr),
		.row_addr(row_addr), .cursor_addr(cursor_addr),
		.cursor_start_row(cursor_start_row), .cursor_end_row(cursor_end_row),
		.cursor_blink_mode(cursor_blink_mode), .display_mode(display_mode),
		.disen(disen), .cursor(cursor)
	);

endmodule

// ==== tb/tb_crtc.sv ====
module tb_crtc;
	// Frame of the test modes is at most 100 clocks, test 5 runs at half rate
	localparam int FRAME_CLKS  = 100;
	localparam int TEST_FRAMES = 40;
	localparam int WATCHDOG    = FRAME_CLKS * TEST_FRAMES * 20 * 4;
	localparam logic [13:0] START = 14'h0120;

	logic        CLK;
	logic        nRESET;
	logic        char_en;
	logic        proc_en;
	logic        cs_n;
	logic        rw;
	logic        a0;
	logic [7:0]  wr_data;
	logic [7:0]  rd_data;
	logic        hsync;
	logic        vsync;
	logic        disen;
	logic        cursor;
	logic [13:0] mem_addr;
	logic [4:0]  row_addr;

	logic        gate_ce;
	logic [31:0] lfsr_state;
	int          errors;
	int          checks;

	crtc_top i_crtc_top (
		.CLK(CLK), .nRESET(nRESET), .char_en(char_en), .proc_en(proc_en),
		.cs_n(cs_n), .rw(rw), .a0(a0), .wr_data(wr_data), .rd_data(rd_data),
		.hsync(hsync), .vsync(vsync), .disen(disen), .cursor(cursor),
		.mem_addr(mem_addr), .row_addr(row_addr)
	);

	always #10 CLK = ~CLK;

	initial begin
		#(WATCHDOG);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Error at %0t: %s", $time, msg);
		end
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	task automatic bus_write(input logic [4:0] idx, input logic [7:0] val);
		cs_n    = 1'b0;
		rw      = 1'b0;
		proc_en = 1'b1;
		a0      = 1'b0;
		wr_data = {3'b000, idx};
		@(posedge CLK);
		#2;
		a0      = 1'b1;
		wr_data = val;
		@(posedge CLK);
		#2;
		cs_n    = 1'b1;
		proc_en = 1'b0;
		a0      = 1'b0;
	endtask

	task automatic bus_read(input logic [4:0] idx, output logic [7:0] val);
		cs_n    = 1'b0;
		rw      = 1'b0;
		proc_en = 1'b1;
		a0      = 1'b0;
		wr_data = {3'b000, idx};
		@(posedge CLK);
		#2;
		// Read data follows the select combinationally
		rw      = 1'b1;
		a0      = 1'b1;
		#1;
		val     = rd_data;
		@(posedge CLK);
		#2;
		cs_n    = 1'b1;
		rw      = 1'b0;
		proc_en = 1'b0;
		a0      = 1'b0;
	endtask

	// Waits for one clock edge that had char_en high
	task automatic char_tick;
		logic fired;
		fired = 1'b0;
		while (!fired) begin
			@(posedge CLK);
			fired = char_en;
			#2;
			if (gate_ce)
				char_en = ~char_en;
		end
	endtask

	function automatic logic probe(input int which);
		case (which)
		0:       return hsync;
		1:       return vsync;
		default: return disen;
		endcase
	endfunction

	task automatic wait_rise(input int which, output int ticks);
		logic prev;
		ticks = 0;
		prev  = probe(which);
		forever begin
			char_tick();
			ticks++;
			if (!prev && probe(which))
				break;
			prev = probe(which);
		end
	endtask

	// Call right after a rise, counts the ticks that stay high
	task automatic high_len(input int which, output int ticks);
		ticks = 1;
		char_tick();
		while (probe(which)) begin
			ticks++;
			char_tick();
		end
	endtask

	task automatic setup_timing(input logic [7:0] r4, input logic [7:0] r5,
		input logic [7:0] r6, input logic [7:0] r7, input logic [7:0] r8,
		input logic [7:0] r9);
		bus_write(5'd0, 8'd9);
		bus_write(5'd1, 8'd6);
		bus_write(5'd2, 8'd7);
		bus_write(5'd3, 8'h22);
		bus_write(5'd4, r4);
		bus_write(5'd5, r5);
		bus_write(5'd6, r6);
		bus_write(5'd7, r7);
		bus_write(5'd8, r8);
		bus_write(5'd9, r9);
		bus_write(5'd12, {2'b00, START[13:8]});
		bus_write(5'd13, START[7:0]);
	endtask

	task automatic reset_and_readback;
		logic [15:0] hi;
		logic [15:0] lo;
		logic [7:0]  val;
		check(!hsync && !vsync && !disen && !cursor, "sync or enable set after reset");
		check(mem_addr == 0 && row_addr == 0, "addresses not zero after reset");
		for (int i = 0; i < 3; i++) begin
			rand_bits(8, hi);
			rand_bits(8, lo);
			bus_write(5'd14, hi[7:0]);
			bus_write(5'd15, lo[7:0]);
			bus_read(5'd14, val);
			check(val == {2'b00, hi[5:0]}, "R14 readback mismatch");
			bus_read(5'd15, val);
			check(val == lo[7:0], "R15 readback mismatch");
		end
		bus_read(5'd0, val);
		check(val == 8'h00, "R0 read is not zero");
		bus_read(5'd12, val);
		check(val == 8'h00, "R12 read is not zero");
	endtask

	task automatic horizontal_timing;
		int t;
		setup_timing(8'd3, 8'd0, 8'd2, 8'd3, 8'h00, 8'd1);
		wait_rise(0, t);
		wait_rise(0, t);
		check(t == 10, "hsync period is not R0+1");
		high_len(0, t);
		check(t == 2, "hsync width is not R3 low nibble");
		wait_rise(2, t);
		high_len(2, t);
		check(t == 6, "disen width is not R1");
	endtask

	task automatic vertical_timing(input logic [7:0] r5);
		int t;
		setup_timing(8'd3, r5, 8'd2, 8'd3, 8'h00, 8'd1);
		wait_rise(1, t);
		wait_rise(1, t);
		check(t == (4 * 2 + r5) * 10, "vsync period is not the frame length");
		high_len(1, t);
		check(t == 2 * 10, "vsync width is not R3 high nibble lines");
	endtask

	task automatic address_sequence;
		int t;
		logic [13:0] exp_ma [4];
		exp_ma = '{START, START, START + 14'd6, START + 14'd6};
		setup_timing(8'd3, 8'd0, 8'd2, 8'd3, 8'h00, 8'd1);
		wait_rise(1, t);
		wait_rise(1, t);
		for (int i = 0; i < 4; i++) begin
			wait_rise(2, t);
			check(mem_addr == exp_ma[i], "mem_addr wrong on first displayed tick");
			check(row_addr == i % 2, "row_addr wrong on displayed line");
		end
	endtask

	task automatic cursor_window(input logic [13:0] target, input logic skewed,
		output int hits, output int idx);
		int   t;
		int   n;
		logic prev;
		wait_rise(1, t);
		wait_rise(1, t);
		hits = 0;
		idx  = -1;
		n    = 0;
		// One whole frame, up to the next vsync rise
		forever begin
			if (cursor) begin
				hits++;
				idx = n;
				if (!skewed)
					check(mem_addr == target && row_addr == 1, "cursor at wrong place");
			end
			prev = vsync;
			char_tick();
			n++;
			if (!prev && vsync)
				break;
		end
	endtask

	task automatic cursor_blink_skew;
		logic [15:0] k;
		logic [13:0] target;
		int hits;
		int idx0;
		int idx1;
		rand_bits(3, k);
		target = START + 14'(k % 6);
		setup_timing(8'd3, 8'd0, 8'd2, 8'd3, 8'h00, 8'd1);
		bus_write(5'd10, 8'h01);
		bus_write(5'd11, 8'h01);
		bus_write(5'd14, {2'b00, target[13:8]});
		bus_write(5'd15, target[7:0]);
		gate_ce = 1'b1;
		cursor_window(target, 1'b0, hits, idx0);
		check(hits == 1, "cursor pulse count wrong with blink mode 0");
		bus_write(5'd8, 8'h40);
		cursor_window(target, 1'b1, hits, idx1);
		check(hits == 1 && idx1 == idx0 + 1, "cursor skew of one tick wrong");
		bus_write(5'd10, 8'h21);
		cursor_window(target, 1'b1, hits, idx1);
		check(hits == 0, "cursor pulsed with blink mode 1");
		gate_ce = 1'b0;
		char_en = 1'b1;
	endtask

	task automatic interlace_rows;
		int t;
		logic [4:0] p0;
		logic [4:0] prev_p;
		setup_timing(8'd3, 8'd0, 8'd1, 8'd2, 8'h03, 8'd3);
		for (int f = 0; f < 4; f++) begin
			wait_rise(1, t);
			while (mem_addr != START)
				char_tick();
			p0 = row_addr;
			check(p0 <= 1, "interlace row_addr does not start at 0 or 1");
			if (f > 0)
				check(p0[0] != prev_p[0], "interlace start parity did not alternate");
			prev_p = p0;
			repeat (10) char_tick();
			check(mem_addr == START && row_addr == p0 + 2, "interlace row step is not 2");
		end
	endtask

	initial begin
		CLK        = 1'b0;
		nRESET     = 1'b0;
		char_en    = 1'b1;
		proc_en    = 1'b0;
		cs_n       = 1'b1;
		rw         = 1'b0;
		a0         = 1'b0;
		wr_data    = 8'h00;
		gate_ce    = 1'b0;
		lfsr_state = 32'hb2cc_62fd;
		errors     = 0;
		checks     = 0;
		repeat (5) @(posedge CLK);
		#2;
		nRESET = 1'b1;
		reset_and_readback();
		horizontal_timing();
		vertical_timing(8'd0);
		vertical_timing(8'd2);
		address_sequence();
		cursor_blink_skew();
		interlace_rows();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
logic/crtc_pkg.sv
logic/crtc_regs.sv
logic/crtc_horiz.sv
logic/crtc_vert.sv
logic/crtc_addr.sv
logic/crtc_video_out.sv
logic/crtc_top.sv
tb/tb_crtc.sv
